// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // data path width
  localparam int xlen = 32;
  typedef logic [xlen-1:0] word_t;

  // register file sizing
  localparam int num_regs = 32;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // minor opcode field
  typedef logic [2:0] funct3_t;

  // one write enable per byte lane of the data port
  typedef logic [xlen/8-1:0] byte_en_t;

  // sequential fetch increment
  localparam word_t pc_step = 32'd4;

  // funct7 pattern that turns add into sub and srl into sra
  localparam logic [6:0] alt_funct7 = 7'b0100000;

  // major opcodes, rv32i base only
  typedef enum logic [6:0] {
    op_load     = 7'b00_000_11,
    op_store    = 7'b01_000_11,
    op_branch   = 7'b11_000_11,
    op_jalr     = 7'b11_001_11,
    op_misc_mem = 7'b00_011_11,
    op_jal      = 7'b11_011_11,
    op_reg_imm  = 7'b00_100_11,
    op_reg_reg  = 7'b01_100_11,
    op_system   = 7'b11_100_11,
    op_auipc    = 7'b00_101_11,
    op_lui      = 7'b01_101_11
  } opcode_t;

  // alu operation select
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    sll    = 4'd2,
    slt    = 4'd3,
    sltu   = 4'd4,
    bxor   = 4'd5,
    srl    = 4'd6,
    sra    = 4'd7,
    bor    = 4'd8,
    band   = 4'd9,
    // forwards operand b untouched, used for lui
    pass_b = 4'd10
  } alu_op_t;

endpackage

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output funct3_t  funct3,
  output word_t    imm_i,
  output word_t    imm_s,
  output word_t    imm_b,
  output word_t    imm_j,
  output word_t    imm_u,
  output alu_op_t  alu_op,
  output logic     alu_use_imm,
  output logic     reg_we,
  output logic     is_load,
  output logic     is_store,
  output logic     is_branch,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_auipc,
  output logic     is_halt
);

  opcode_t    opcode;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  assign opcode = opcode_t'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign f7_zero = (funct7 == 7'd0);
  assign f7_alt  = (funct7 == alt_funct7);

  // immediates, all sign extended from insn[31] except u
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  always_comb begin
    alu_op      = add;
    alu_use_imm = 1'b0;
    reg_we      = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_auipc    = 1'b0;
    is_halt     = 1'b0;

    // base operation from funct3, sub and sra picked up below
    case (funct3)
      3'b000: alu_op = (opcode == op_reg_reg && f7_alt) ? sub : add;
      3'b001: alu_op = sll;
      3'b010: alu_op = slt;
      3'b011: alu_op = sltu;
      3'b100: alu_op = bxor;
      3'b101: alu_op = f7_alt ? sra : srl;
      3'b110: alu_op = bor;
      default: alu_op = band;
    endcase

    case (opcode)
      op_lui: begin
        alu_op      = pass_b;
        alu_use_imm = 1'b1;
        reg_we      = 1'b1;
      end
      op_auipc: begin
        reg_we   = 1'b1;
        is_auipc = 1'b1;
      end
      op_jal: begin
        reg_we = 1'b1;
        is_jal = 1'b1;
      end
      op_jalr: begin
        reg_we  = (funct3 == 3'b000);
        is_jalr = (funct3 == 3'b000);
      end
      // funct3 010 and 011 are not branches
      op_branch: is_branch = (funct3[2:1] != 2'b01);
      op_load: begin
        reg_we  = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        is_load = reg_we;
      end
      op_store: is_store = (funct3 inside {3'b000, 3'b001, 3'b010});
      op_reg_imm: begin
        // funct7 only constrains the shift forms
        reg_we = (funct3 != 3'b001 && funct3 != 3'b101) || f7_zero ||
                 (funct3 == 3'b101 && f7_alt);
        alu_use_imm = reg_we;
      end
      // funct7 of 1 is the m extension, left as a no-op
      op_reg_reg: reg_we = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      op_system: is_halt = (insn[31:7] == 25'd0);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     we,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [num_regs];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits of b count for shifts
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      add:    result = a + b;
      sub:    result = a - b;
      sll:    result = a << shamt;
      slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      bxor:   result = a ^ b;
      srl:    result = a >> shamt;
      sra:    result = word_t'($signed(a) >>> shamt);
      bor:    result = a | b;
      band:   result = a & b;
      pass_b: result = b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_pc_unit.sv ====
`default_nettype none

module rv_pc_unit import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    is_branch,
  input  logic    is_jal,
  input  logic    is_jalr,
  input  funct3_t funct3,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm_b,
  input  word_t   imm_j,
  input  word_t   imm_i,
  output word_t   pc,
  output word_t   pc_plus4
);

  logic  taken;
  word_t pc_next;

  assign pc_plus4 = pc + pc_step;

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000: taken = (rs1_data == rs2_data);
      3'b001: taken = (rs1_data != rs2_data);
      3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110: taken = rs1_data < rs2_data;
      3'b111: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_branch && taken) begin
      pc_next = pc + imm_b;
    end else if (is_jal) begin
      pc_next = pc + imm_j;
    end else if (is_jalr) begin
      // jalr target drops bit 0
      pc_next = (rs1_data + imm_i) & ~word_t'(1);
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_lsu.sv ====
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  logic     is_load,
  input  logic     is_store,
  input  funct3_t  funct3,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    imm_i,
  input  word_t    imm_s,
  input  word_t    load_data,
  output word_t    dmem_addr,
  output word_t    store_data,
  output byte_en_t store_we,
  output word_t    load_value
);

  word_t      eff_addr;
  logic [1:0] offset;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  // loads use the i immediate, stores the s immediate
  assign eff_addr  = rs1_data + (is_load ? imm_i : imm_s);
  assign offset    = eff_addr[1:0];
  assign dmem_addr = {eff_addr[xlen-1:2], 2'b00};

  // data goes out on every lane, the enables pick the ones that land
  always_comb begin
    case (funct3)
      3'b000:  store_data = {4{rs2_data[7:0]}};
      3'b001:  store_data = {2{rs2_data[15:0]}};
      default: store_data = rs2_data;
    endcase
  end

  always_comb begin
    store_we = '0;
    if (is_store) begin
      case (funct3)
        3'b000:  store_we = byte_en_t'(4'b0001 << offset);
        3'b001:  store_we = offset[1] ? 4'b1100 : 4'b0011;
        3'b010:  store_we = 4'b1111;
        default: store_we = '0;
      endcase
    end
  end

  // misaligned halfwords take the half selected by bit 1
  assign ld_byte = load_data[8*offset +: 8];
  assign ld_half = offset[1] ? load_data[31:16] : load_data[15:0];

  always_comb begin
    case (funct3)
      3'b000:  load_value = {{24{ld_byte[7]}}, ld_byte};
      3'b001:  load_value = {{16{ld_half[15]}}, ld_half};
      3'b100:  load_value = {24'd0, ld_byte};
      3'b101:  load_value = {16'd0, ld_half};
      default: load_value = load_data;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output word_t    pc,
  input  word_t    insn,
  output word_t    dmem_addr,
  output word_t    store_data,
  output byte_en_t store_we,
  input  word_t    load_data,
  output logic     halt
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  funct3_t  funct3;
  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_b;
  word_t    imm_j;
  word_t    imm_u;
  alu_op_t  alu_op;
  logic     alu_use_imm;
  logic     reg_we;
  logic     is_load;
  logic     is_store;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_auipc;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_b;
  word_t    alu_result;
  word_t    load_value;
  word_t    pc_plus4;
  word_t    rd_data;

  rv_decoder u_decoder (
    .insn        (insn),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .funct3      (funct3),
    .imm_i       (imm_i),
    .imm_s       (imm_s),
    .imm_b       (imm_b),
    .imm_j       (imm_j),
    .imm_u       (imm_u),
    .alu_op      (alu_op),
    .alu_use_imm (alu_use_imm),
    .reg_we      (reg_we),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_auipc    (is_auipc),
    .is_halt     (halt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (reg_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // pass_b only comes from lui, which carries the u immediate
  assign alu_b = !alu_use_imm ? rs2_data : (alu_op == pass_b) ? imm_u : imm_i;

  rv_alu u_alu (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .funct3    (funct3),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm_b     (imm_b),
    .imm_j     (imm_j),
    .imm_i     (imm_i),
    .pc        (pc),
    .pc_plus4  (pc_plus4)
  );

  rv_lsu u_lsu (
    .is_load    (is_load),
    .is_store   (is_store),
    .funct3     (funct3),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm_i      (imm_i),
    .imm_s      (imm_s),
    .load_data  (load_data),
    .dmem_addr  (dmem_addr),
    .store_data (store_data),
    .store_we   (store_we),
    .load_value (load_value)
  );

  // writeback select
  always_comb begin
    if (is_load) begin
      rd_data = load_value;
    end else if (is_jal || is_jalr) begin
      rd_data = pc_plus4;
    end else if (is_auipc) begin
      rd_data = pc + imm_u;
    end else begin
      rd_data = alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== dv/rv_core_properties.sv ====
`default_nettype none

module rv_core_properties import rv_pkg::*; (
  input logic     clk,
  input logic     rst,
  input word_t    pc,
  input word_t    dmem_addr,
  input byte_en_t store_we
);

  // pc is unknown before the first reset edge
  logic past_valid;

  initial past_valid = 1'b0;

  always @(posedge clk) begin
    past_valid <= 1'b1;
  end

  no_store_in_reset: assert property (@(posedge clk) (past_valid && rst) |-> store_we == '0)
    else $error("store enable active while reset is high");

  dmem_addr_aligned: assert property (@(posedge clk) dmem_addr[1:0] == 2'b00)
    else $error("data address is not word aligned");

  pc_aligned: assert property (@(posedge clk) (past_valid && !rst) |=> pc[1:0] == 2'b00)
    else $error("pc moved to an address that is not a multiple of 4");

endmodule

bind rv_core rv_core_properties u_properties (
  .clk       (clk),
  .rst       (rst),
  .pc        (pc),
  .dmem_addr (dmem_addr),
  .store_we  (store_we)
);

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  localparam int mem_words = 8192;
  localparam int max_cycles = 5000;

  logic     clk;
  logic     rst;
  word_t    pc;
  word_t    insn;
  word_t    dmem_addr;
  word_t    store_data;
  byte_en_t store_we;
  word_t    load_data;
  logic     halt;

  // memory seen by the core, and the copy kept by the reference model
  word_t mem [mem_words];
  word_t ref_mem [mem_words];
  word_t ref_regs [num_regs];
  word_t ref_pc;
  logic  ref_halted;

  int          wr_ptr;
  logic [10:0] st_off;

  rv_core UUT (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .store_data (store_data),
    .store_we   (store_we),
    .load_data  (load_data),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // combinational reads, byte lane writes at the edge
  assign insn      = mem[pc[14:2]];
  assign load_data = mem[dmem_addr[14:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (store_we[i]) begin
        mem[dmem_addr[14:2]][8*i +: 8] <= store_data[8*i +: 8];
      end
    end
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                   reg_idx_t rd, opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd,
                                   opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic emit(input word_t w);
    mem[wr_ptr] <= w;
    ref_mem[wr_ptr] = w;
    wr_ptr++;
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_idx_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h800;
    emit(u_type(hi[31:12], rd, op_lui));
    emit(i_type(v[11:0], rd, 3'b000, rd, op_reg_imm));
  endtask

  // sw into the result area at 0x6000 through x31
  task automatic store_result(input reg_idx_t rs);
    emit(s_type({1'b0, st_off}, rs, 5'd31, 3'b010));
    st_off = st_off + 11'd4;
  endtask

  function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // executes one instruction on the reference state
  function automatic void ref_step(output word_t e_pc, output word_t e_addr,
                                   output word_t e_data, output byte_en_t e_we,
                                   output logic e_halt, output logic e_mem);
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      wb;
    word_t      npc;
    word_t      addr;
    word_t      word;
    logic       wr;
    logic [6:0] op;
    logic [6:0] f7;
    funct3_t    f3;
    reg_idx_t   rd;
    logic [1:0] off;

    w     = ref_mem[ref_pc[14:2]];
    op    = w[6:0];
    rd    = w[11:7];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = ref_regs[w[19:15]];
    b     = ref_regs[w[24:20]];
    imm_i = $signed(w) >>> 20;
    imm_s = $signed({w[31:25], w[11:7], 20'd0}) >>> 20;
    imm_b = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'd0}) >>> 19;
    imm_j = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'd0}) >>> 11;
    imm_u = {w[31:12], 12'd0};

    e_pc   = ref_pc;
    e_addr = '0;
    e_data = '0;
    e_we   = '0;
    e_halt = 1'b0;
    e_mem  = 1'b0;
    wr     = 1'b0;
    wb     = '0;
    npc    = ref_pc + 32'd4;

    case (op)
      op_lui: begin
        wr = 1'b1;
        wb = imm_u;
      end
      op_auipc: begin
        wr = 1'b1;
        wb = ref_pc + imm_u;
      end
      op_jal: begin
        wr  = 1'b1;
        wb  = ref_pc + 32'd4;
        npc = ref_pc + imm_j;
      end
      op_jalr: begin
        wr  = 1'b1;
        wb  = ref_pc + 32'd4;
        npc = (a + imm_i) & 32'hFFFF_FFFE;
      end
      op_branch: begin
        if (branch_taken(f3, a, b)) begin
          npc = ref_pc + imm_b;
        end
      end
      op_load: begin
        addr   = a + imm_i;
        off    = addr[1:0];
        word   = ref_mem[addr[14:2]];
        e_mem  = 1'b1;
        e_addr = {addr[31:2], 2'b00};
        wr     = 1'b1;
        case (f3)
          3'b000: wb = $signed(word << (24 - 8*off)) >>> 24;
          3'b001: wb = $signed(word << (16 - 8*off)) >>> 16;
          3'b100: wb = (word >> (8*off)) & 32'h0000_00FF;
          3'b101: wb = (word >> (8*off)) & 32'h0000_FFFF;
          default: wb = word;
        endcase
      end
      op_store: begin
        addr   = a + imm_s;
        off    = addr[1:0];
        e_mem  = 1'b1;
        e_addr = {addr[31:2], 2'b00};
        case (f3)
          3'b000: begin
            e_we   = byte_en_t'(4'b0001 << off);
            e_data = {24'd0, b[7:0]} << (8*off);
          end
          3'b001: begin
            e_we   = byte_en_t'(4'b0011 << off);
            e_data = {16'd0, b[15:0]} << (8*off);
          end
          default: begin
            e_we   = 4'b1111;
            e_data = b;
          end
        endcase
        for (int i = 0; i < 4; i++) begin
          if (e_we[i]) begin
            ref_mem[addr[14:2]][8*i +: 8] = e_data[8*i +: 8];
          end
        end
      end
      op_reg_imm: begin
        wr = 1'b1;
        wb = alu_ref(f3, f3 == 3'b101 && f7 == alt_funct7, a, imm_i);
      end
      op_reg_reg: begin
        // funct7 of 1 is a multiply or divide, which the core ignores
        if (f7 != 7'd1) begin
          wr = 1'b1;
          wb = alu_ref(f3, f7 == alt_funct7, a, b);
        end
      end
      op_system: e_halt = (w == 32'h0000_0073);
      default: ;
    endcase

    if (wr && rd != 5'd0) begin
      ref_regs[rd] = wb;
    end
    ref_pc = npc;
  endfunction

  task automatic build_program();
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic        alt;
    word_t       v1;
    word_t       v2;
    int          mode;

    for (int i = 0; i < mem_words; i++) begin
      v1 = (word_t'(i) * 32'h9E37_79B1) ^ 32'hA5A5_0000;
      mem[i] <= v1;
      ref_mem[i] = v1;
    end
    wr_ptr = 0;
    st_off = '0;

    load_const(5'd31, 32'h0000_6000);
    for (int r = 1; r < 16; r++) begin
      load_const(reg_idx_t'(r), $urandom);
    end

    // random alu instructions, each result stored
    for (int k = 0; k < 200; k++) begin
      rd  = reg_idx_t'($urandom % 16);
      rs1 = reg_idx_t'($urandom % 16);
      rs2 = reg_idx_t'($urandom % 16);
      f3  = funct3_t'($urandom % 8);
      alt = ($urandom % 2) == 1;
      if ($urandom % 2 == 0) begin
        f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? alt_funct7 : 7'd0;
        emit(r_type(f7, rs2, rs1, f3, rd, op_reg_reg));
      end else begin
        imm = 12'($urandom);
        if (f3 == 3'b001) begin
          imm = {7'd0, imm[4:0]};
        end else if (f3 == 3'b101) begin
          imm = {alt ? alt_funct7 : 7'd0, imm[4:0]};
        end
        emit(i_type(imm, rs1, f3, rd, op_reg_imm));
      end
      store_result(rd);
    end

    // upper immediates and jumps
    emit(u_type(20'($urandom), 5'd20, op_lui));
    store_result(5'd20);
    emit(u_type(20'($urandom), 5'd21, op_auipc));
    store_result(5'd21);
    emit(j_type(21'd8, 5'd22));
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd22, op_reg_imm));
    store_result(5'd22);
    // forward, back by one word, then forward past the chain
    emit(j_type(21'd8, 5'd0));
    emit(j_type(21'd8, 5'd23));
    emit(j_type(21'h1F_FFFC, 5'd24));
    store_result(5'd23);
    store_result(5'd24);
    // odd jalr offset, bit 0 of the target is dropped
    emit(u_type(20'd0, 5'd25, op_auipc));
    emit(i_type(12'd13, 5'd25, 3'b000, 5'd26, op_jalr));
    emit(i_type(12'd7, 5'd0, 3'b000, 5'd26, op_reg_imm));
    store_result(5'd25);
    store_result(5'd26);

    // branches, x27 counts the fall-through paths
    for (int t = 0; t < 8; t++) begin
      if (t == 2 || t == 3) begin
        continue;
      end
      repeat (8) begin
        mode = $urandom % 3;
        v1 = $urandom;
        v2 = (mode == 0) ? v1 : $urandom;
        if (mode == 2) begin
          v1 = ($urandom % 9) - 32'd4;
          v2 = ($urandom % 9) - 32'd4;
        end
        load_const(5'd1, v1);
        load_const(5'd2, v2);
        emit(b_type(13'd8, 5'd2, 5'd1, funct3_t'(t)));
        emit(i_type(12'd1, 5'd27, 3'b000, 5'd27, op_reg_imm));
      end
    end
    store_result(5'd27);

    // stores at every lane, each read back with both extensions
    load_const(5'd30, 32'h0000_7000);
    repeat (3) begin
      for (int off = 0; off < 4; off++) begin
        load_const(5'd5, $urandom);
        emit(s_type(12'(off), 5'd5, 5'd30, 3'b000));
        emit(i_type(12'(off), 5'd30, 3'b000, 5'd6, op_load));
        store_result(5'd6);
        emit(i_type(12'(off), 5'd30, 3'b100, 5'd7, op_load));
        store_result(5'd7);
      end
      for (int off = 0; off < 4; off += 2) begin
        load_const(5'd5, $urandom);
        emit(s_type(12'(off), 5'd5, 5'd30, 3'b001));
        emit(i_type(12'(off), 5'd30, 3'b001, 5'd6, op_load));
        store_result(5'd6);
        emit(i_type(12'(off), 5'd30, 3'b101, 5'd7, op_load));
        store_result(5'd7);
      end
      load_const(5'd5, $urandom);
      emit(s_type(12'd0, 5'd5, 5'd30, 3'b010));
      emit(i_type(12'd0, 5'd30, 3'b010, 5'd6, op_load));
      store_result(5'd6);
    end

    // fence and m extension encodings leave the registers alone
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, op_misc_mem));
    repeat (4) begin
      rd  = reg_idx_t'(1 + $urandom % 15);
      rs1 = reg_idx_t'($urandom % 16);
      rs2 = reg_idx_t'($urandom % 16);
      emit(r_type(7'd1, rs2, rs1, funct3_t'($urandom % 8), rd, op_reg_reg));
      store_result(rd);
    end
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, op_system));
  endtask

  // compares the core against the reference once per instruction
  initial begin : compare
    word_t    e_pc;
    word_t    e_addr;
    word_t    e_data;
    word_t    mask;
    byte_en_t e_we;
    logic     e_halt;
    logic     e_mem;

    forever begin
      @(negedge clk);
      if (!rst && !ref_halted) begin
        ref_step(e_pc, e_addr, e_data, e_we, e_halt, e_mem);
        for (int i = 0; i < 4; i++) begin
          mask[8*i +: 8] = {8{e_we[i]}};
        end
        check_value("pc", pc, e_pc);
        check_value("halt", word_t'(halt), word_t'(e_halt));
        check_value("store_we", word_t'(store_we), word_t'(e_we));
        if (e_mem) begin
          check_value("dmem_addr", dmem_addr, e_addr);
        end
        check_value("store_data", store_data & mask, e_data & mask);
        if (e_halt) begin
          ref_halted = 1'b1;
        end
      end
    end
  end

  initial begin
    int cycles;

    void'($urandom(45));
    rst        = 1'b1;
    ref_pc     = '0;
    ref_halted = 1'b0;
    for (int r = 0; r < num_regs; r++) begin
      ref_regs[r] = '0;
    end
    build_program();

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_value("pc", pc, 32'd0);
    check_value("store_we", word_t'(store_we), 32'd0);
    check_value("halt", word_t'(halt), 32'd0);

    cycles = 0;
    while (!ref_halted) begin
      @(posedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        $display("the program never halted within %0d cycles", max_cycles);
        $display("Result: FAILED");
        $fatal(1, "timeout waiting for halt");
      end
    end

    // the whole memory must match the reference copy
    for (int i = 0; i < mem_words; i++) begin
      check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_lsu.sv
hw/rv_core.sv
dv/rv_core_properties.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
log_file="sim.log"

verilator --binary --assert -Wno-fatal \
  --top-module tb_rv_core \
  -f rv_core.f \
  --Mdir "${build_dir}" \
  -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./${build_dir}/tb_rv_core" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
fi

if grep -qx "Result: PASSED" "${log_file}"; then
  exit 0
fi
echo "pass message not found in ${log_file}"
exit 1
